// ==== logic/xbar_cfg.svh ====
`ifndef XBAR_CFG_SVH
`define XBAR_CFG_SVH

// crossbar size
`define XBAR_NM 2
`define XBAR_NS 2

// bus widths
`define XBAR_AW 32
`define XBAR_DW 32

// address map, region is the top nibble of the address
`define XBAR_RGN_W 4
`define XBAR_SLV0_RGN 4'h0
`define XBAR_SLV1_RGN 4'h1

// outstanding reads per master, full at 7
`define XBAR_LG_PEND 3

// response for reads that hit no slave
`define XBAR_ERR_RESP 2'b11

`endif

// ==== logic/xbar_pkg.sv ====
`include "xbar_cfg.svh"

package xbar_pkg;

	// region and offset view of an address
	typedef struct packed {
		logic [`XBAR_RGN_W-1:0]          region;
		logic [`XBAR_AW-`XBAR_RGN_W-1:0] offset;
	} addr_fields_t;

	// raw word for the bus, fields for the decoder
	typedef union packed {
		logic [`XBAR_AW-1:0] word;
		addr_fields_t        fields;
	} addr_t;

	typedef logic [`XBAR_DW-1:0] data_t;
	typedef logic [1:0] resp_t;
	typedef logic [2:0] prot_t;

	// one-hot slave select, top bit is the error slot
	typedef logic [`XBAR_NS:0] sel_t;

	typedef logic [`XBAR_LG_PEND-1:0] pend_t;

endpackage

// ==== logic/rd_skid_buffer.sv ====
`timescale 1ns/1ps

module rd_skid_buffer (
	input  logic            S_AXI_ACLK,
	input  logic            S_AXI_ARESETN,
	input  logic            i_valid,
	output logic            o_ready,
	input  xbar_pkg::addr_t i_addr,
	input  xbar_pkg::prot_t i_prot,
	output logic            o_valid,
	input  logic            i_stall,
	output xbar_pkg::addr_t o_addr,
	output xbar_pkg::prot_t o_prot
);

	logic            r_valid;
	xbar_pkg::addr_t r_addr;
	xbar_pkg::prot_t r_prot;

	// park the beat when downstream stalls while we accept
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && i_stall)
			r_valid <= 1'b1;
		else if (!i_stall)
			r_valid <= 1'b0;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
		begin
			r_addr <= i_addr;
			r_prot <= i_prot;
		end
	end

	// upstream ready comes straight from a register
	assign o_ready = !r_valid;

	assign o_valid = i_valid || r_valid;
	assign o_addr  = r_valid ? r_addr : i_addr;
	assign o_prot  = r_valid ? r_prot : i_prot;

endmodule

// ==== logic/rd_addr_decode.sv ====
`timescale 1ns/1ps
`include "xbar_cfg.svh"

module rd_addr_decode (
	input  logic            S_AXI_ACLK,
	input  logic            S_AXI_ARESETN,
	input  logic            i_valid,
	output logic            o_stall,
	input  xbar_pkg::addr_t i_addr,
	input  xbar_pkg::prot_t i_prot,
	output logic            o_valid,
	input  logic            i_stall,
	output xbar_pkg::sel_t  o_sel,
	output xbar_pkg::addr_t o_addr,
	output xbar_pkg::prot_t o_prot
);

	xbar_pkg::sel_t dec_sel;

	// match the region field against each slave window
	always_comb
	begin
		dec_sel = '0;
		dec_sel[0] = (i_addr.fields.region == `XBAR_SLV0_RGN);
		dec_sel[1] = (i_addr.fields.region == `XBAR_SLV1_RGN);
		// nothing matched, route to the error slot
		dec_sel[`XBAR_NS] = ~|dec_sel[`XBAR_NS-1:0];
	end

	// only a held request blocks the upstream
	assign o_stall = o_valid && i_stall;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_valid <= 1'b0;
		else if (!o_stall)
			o_valid <= i_valid;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_stall)
		begin
			o_sel  <= dec_sel;
			o_addr <= i_addr;
			o_prot <= i_prot;
		end
	end

endmodule

// ==== logic/rd_master_arbiter.sv ====
`timescale 1ns/1ps
`include "xbar_cfg.svh"

module rd_master_arbiter (
	input  logic             S_AXI_ACLK,
	input  logic             S_AXI_ARESETN,
	input  logic             i_valid,
	input  xbar_pkg::sel_t   i_sel,
	input  xbar_pkg::sel_t   i_higher_req,
	input  xbar_pkg::sel_t   i_other_grant,
	input  logic             i_slave_stall,
	input  logic             i_rsp_done,
	input  logic             i_rsp_stall,
	output xbar_pkg::sel_t   o_grant,
	output logic             o_accept,
	output logic             o_empty
);

	xbar_pkg::sel_t  req;
	xbar_pkg::pend_t pend;
	logic            hit;
	logic            full;
	logic            stay;
	logic            avail;
	logic            path_stall;

	assign req  = i_valid ? i_sel : '0;
	assign hit  = |(req & o_grant);
	assign full = &pend;

	assign o_empty = (pend == '0);

	// keep the slave while we use it or still owe responses
	assign stay = hit || !o_empty;

	// slave must be free and not wanted by a lower master
	// the error slot is never contended
	assign avail = req[`XBAR_NS]
		|| |(req[`XBAR_NS-1:0] & ~i_other_grant[`XBAR_NS-1:0]
			& ~i_higher_req[`XBAR_NS-1:0]);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_grant <= '0;
		else if (!stay)
			o_grant <= avail ? req : '0;
	end

	// error reads go straight to the return path
	assign path_stall = o_grant[`XBAR_NS] ? i_rsp_stall : i_slave_stall;

	assign o_accept = hit && !full && !path_stall;

	// reads in flight, from accept to R transfer
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			pend <= '0;
		else
		begin
			case ({o_accept, i_rsp_done})
			2'b10:
				pend <= pend + 1'b1;
			2'b01:
				pend <= pend - 1'b1;
			default:
				pend <= pend;
			endcase
		end
	end

endmodule

// ==== logic/rd_slave_port.sv ====
`timescale 1ns/1ps
`include "xbar_cfg.svh"

module rd_slave_port (
	input  logic                                  S_AXI_ACLK,
	input  logic                                  S_AXI_ARESETN,
	input  logic            [`XBAR_NM-1:0]        i_grant,
	input  logic            [`XBAR_NM-1:0]        i_valid,
	input  logic            [`XBAR_NM-1:0]        i_accept,
	input  xbar_pkg::addr_t [`XBAR_NM-1:0]        i_addr,
	input  xbar_pkg::prot_t [`XBAR_NM-1:0]        i_prot,
	input  logic            [`XBAR_NM-1:0]        i_ret_ready,
	output logic                                  o_arvalid,
	output xbar_pkg::addr_t                       o_araddr,
	output xbar_pkg::prot_t                       o_arprot,
	input  logic                                  i_arready,
	output logic                                  o_rready
);

	logic            owned;
	logic            ar_stall;
	logic            sel_valid;
	xbar_pkg::addr_t sel_addr;
	xbar_pkg::prot_t sel_prot;

	assign owned    = |i_grant;
	assign ar_stall = o_arvalid && !i_arready;

	// at most one grant bit is set, so an and-or mux picks the owner
	always_comb
	begin
		sel_valid     = |(i_grant & i_valid & i_accept);
		sel_addr.word = '0;
		sel_prot      = '0;
		for (int n = 0; n < `XBAR_NM; n++)
		begin
			sel_addr.word = sel_addr.word | (i_addr[n].word & {`XBAR_AW{i_grant[n]}});
			sel_prot      = sel_prot | (i_prot[n] & {3{i_grant[n]}});
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || !owned)
			o_arvalid <= 1'b0;
		else if (!ar_stall)
			o_arvalid <= sel_valid;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!ar_stall)
		begin
			o_araddr <= sel_addr;
			o_arprot <= sel_prot;
		end
	end

	// idle slave ports stay ready
	assign o_rready = owned ? |(i_grant & i_ret_ready) : 1'b1;

endmodule

// ==== logic/rd_return_channel.sv ====
`timescale 1ns/1ps
`include "xbar_cfg.svh"

module rd_return_channel (
	input  logic                                  S_AXI_ACLK,
	input  logic                                  S_AXI_ARESETN,
	input  xbar_pkg::sel_t                        i_grant,
	input  logic                                  i_err_accept,
	input  logic            [`XBAR_NS-1:0]        i_rvalid,
	input  xbar_pkg::data_t [`XBAR_NS-1:0]        i_rdata,
	input  xbar_pkg::resp_t [`XBAR_NS-1:0]        i_rresp,
	output logic                                  o_ret_ready,
	output logic                                  o_rvalid,
	output xbar_pkg::data_t                       o_rdata,
	output xbar_pkg::resp_t                       o_rresp,
	input  logic                                  i_rready
);

	logic            stall;
	logic            slv_xfer;
	logic            in_valid;
	xbar_pkg::data_t mux_data;
	xbar_pkg::resp_t mux_resp;
	logic            bk_valid;
	xbar_pkg::data_t bk_data;
	xbar_pkg::resp_t bk_resp;

	assign stall = o_rvalid && !i_rready;

	// transfer from the granted slave
	assign slv_xfer = |(i_grant[`XBAR_NS-1:0] & i_rvalid) && o_ret_ready;
	assign in_valid = i_grant[`XBAR_NS] ? i_err_accept : slv_xfer;

	always_comb
	begin
		mux_data = '0;
		mux_resp = '0;
		for (int s = 0; s < `XBAR_NS; s++)
		begin
			mux_data = mux_data | (i_rdata[s] & {`XBAR_DW{i_grant[s]}});
			mux_resp = mux_resp | (i_rresp[s] & {2{i_grant[s]}});
		end
		// error reads return zero data
		if (i_grant[`XBAR_NS])
		begin
			mux_data = '0;
			mux_resp = `XBAR_ERR_RESP;
		end
	end

	// catch one response that lands while the master stalls
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || !stall)
			bk_valid <= 1'b0;
		else if (!bk_valid)
			bk_valid <= slv_xfer;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!bk_valid)
		begin
			bk_data <= mux_data;
			bk_resp <= mux_resp;
		end
	end

	// slave sees ready drop once the backup is full
	assign o_ret_ready = !bk_valid;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rvalid <= 1'b0;
		else if (!stall)
			o_rvalid <= bk_valid || in_valid;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!stall)
		begin
			o_rdata <= bk_valid ? bk_data : mux_data;
			o_rresp <= bk_valid ? bk_resp : mux_resp;
		end
	end

endmodule

// ==== logic/axil_rd_xbar.sv ====
`timescale 1ns/1ps
`include "xbar_cfg.svh"

module axil_rd_xbar (
	input  logic                                  S_AXI_ACLK,
	input  logic                                  S_AXI_ARESETN,
	input  logic            [`XBAR_NM-1:0]        S_AXI_ARVALID,
	output logic            [`XBAR_NM-1:0]        S_AXI_ARREADY,
	input  xbar_pkg::addr_t [`XBAR_NM-1:0]        S_AXI_ARADDR,
	input  xbar_pkg::prot_t [`XBAR_NM-1:0]        S_AXI_ARPROT,
	output logic            [`XBAR_NM-1:0]        S_AXI_RVALID,
	input  logic            [`XBAR_NM-1:0]        S_AXI_RREADY,
	output xbar_pkg::data_t [`XBAR_NM-1:0]        S_AXI_RDATA,
	output xbar_pkg::resp_t [`XBAR_NM-1:0]        S_AXI_RRESP,
	output logic            [`XBAR_NS-1:0]        M_AXI_ARVALID,
	input  logic            [`XBAR_NS-1:0]        M_AXI_ARREADY,
	output xbar_pkg::addr_t [`XBAR_NS-1:0]        M_AXI_ARADDR,
	output xbar_pkg::prot_t [`XBAR_NS-1:0]        M_AXI_ARPROT,
	input  logic            [`XBAR_NS-1:0]        M_AXI_RVALID,
	output logic            [`XBAR_NS-1:0]        M_AXI_RREADY,
	input  xbar_pkg::data_t [`XBAR_NS-1:0]        M_AXI_RDATA,
	input  xbar_pkg::resp_t [`XBAR_NS-1:0]        M_AXI_RRESP
);

	logic            [`XBAR_NM-1:0] skd_valid, skd_stall;
	xbar_pkg::addr_t [`XBAR_NM-1:0] skd_addr;
	xbar_pkg::prot_t [`XBAR_NM-1:0] skd_prot;
	logic            [`XBAR_NM-1:0] dcd_valid, dcd_stall;
	xbar_pkg::sel_t  [`XBAR_NM-1:0] dcd_sel;
	xbar_pkg::addr_t [`XBAR_NM-1:0] dcd_addr;
	xbar_pkg::prot_t [`XBAR_NM-1:0] dcd_prot;
	xbar_pkg::sel_t  [`XBAR_NM-1:0] grant, other_grant;
	logic            [`XBAR_NM-1:0] accept, slave_stall, ret_ready;
	// running ORs, entry n covers masters below n
	xbar_pkg::sel_t  [`XBAR_NM:0]   req_or, grant_or;
	logic [`XBAR_NS-1:0][`XBAR_NM-1:0] slv_grant;

	assign req_or[0]   = '0;
	assign grant_or[0] = '0;

	genvar n, s;
	generate
		for (n = 0; n < `XBAR_NM; n++)
		begin : gen_master
			assign req_or[n+1]    = req_or[n] | (dcd_valid[n] ? dcd_sel[n] : '0);
			assign grant_or[n+1]  = grant_or[n] | grant[n];
			assign other_grant[n] = grant_or[`XBAR_NM] & ~grant[n];
			assign dcd_stall[n]   = dcd_valid[n] && !accept[n];
			assign slave_stall[n] = |(grant[n][`XBAR_NS-1:0] & M_AXI_ARVALID & ~M_AXI_ARREADY);

			rd_skid_buffer skid_inst (
				.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
				.i_valid(S_AXI_ARVALID[n]), .o_ready(S_AXI_ARREADY[n]),
				.i_addr(S_AXI_ARADDR[n]), .i_prot(S_AXI_ARPROT[n]),
				.o_valid(skd_valid[n]), .i_stall(skd_stall[n]),
				.o_addr(skd_addr[n]), .o_prot(skd_prot[n])
			);

			rd_addr_decode decode_inst (
				.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
				.i_valid(skd_valid[n]), .o_stall(skd_stall[n]),
				.i_addr(skd_addr[n]), .i_prot(skd_prot[n]),
				.o_valid(dcd_valid[n]), .i_stall(dcd_stall[n]),
				.o_sel(dcd_sel[n]), .o_addr(dcd_addr[n]), .o_prot(dcd_prot[n])
			);

			rd_master_arbiter arb_inst (
				.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
				.i_valid(dcd_valid[n]), .i_sel(dcd_sel[n]),
				.i_higher_req(req_or[n]), .i_other_grant(other_grant[n]),
				.i_slave_stall(slave_stall[n]),
				.i_rsp_done(S_AXI_RVALID[n] && S_AXI_RREADY[n]),
				.i_rsp_stall(S_AXI_RVALID[n] && !S_AXI_RREADY[n]),
				.o_grant(grant[n]), .o_accept(accept[n]), .o_empty()
			);

			rd_return_channel ret_inst (
				.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
				.i_grant(grant[n]),
				.i_err_accept(accept[n] && grant[n][`XBAR_NS]),
				.i_rvalid(M_AXI_RVALID), .i_rdata(M_AXI_RDATA), .i_rresp(M_AXI_RRESP),
				.o_ret_ready(ret_ready[n]),
				.o_rvalid(S_AXI_RVALID[n]), .o_rdata(S_AXI_RDATA[n]),
				.o_rresp(S_AXI_RRESP[n]), .i_rready(S_AXI_RREADY[n])
			);
		end

		for (s = 0; s < `XBAR_NS; s++)
		begin : gen_slave
			for (n = 0; n < `XBAR_NM; n++)
			begin : gen_own
				assign slv_grant[s][n] = grant[n][s];
			end

			rd_slave_port port_inst (
				.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
				.i_grant(slv_grant[s]), .i_valid(dcd_valid), .i_accept(accept),
				.i_addr(dcd_addr), .i_prot(dcd_prot), .i_ret_ready(ret_ready),
				.o_arvalid(M_AXI_ARVALID[s]), .o_araddr(M_AXI_ARADDR[s]),
				.o_arprot(M_AXI_ARPROT[s]), .i_arready(M_AXI_ARREADY[s]),
				.o_rready(M_AXI_RREADY[s])
			);
		end
	endgenerate

endmodule

// ==== dv/axil_rd_xbar_assert.sv ====
`timescale 1ns/1ps
`include "xbar_cfg.svh"

module axil_rd_xbar_assert (
	input  logic                                  S_AXI_ACLK,
	input  logic                                  S_AXI_ARESETN,
	input  logic            [`XBAR_NM-1:0]        i_s_rvalid,
	input  logic            [`XBAR_NM-1:0]        i_s_rready,
	input  xbar_pkg::data_t [`XBAR_NM-1:0]        i_s_rdata,
	input  xbar_pkg::resp_t [`XBAR_NM-1:0]        i_s_rresp,
	input  logic            [`XBAR_NS-1:0]        i_m_arvalid,
	input  logic            [`XBAR_NS-1:0]        i_m_arready,
	input  xbar_pkg::addr_t [`XBAR_NS-1:0]        i_m_araddr,
	input  xbar_pkg::prot_t [`XBAR_NS-1:0]        i_m_arprot,
	input  xbar_pkg::sel_t  [`XBAR_NM-1:0]        i_grant
);

	genvar m, s;
	generate
		for (m = 0; m < `XBAR_NM; m++)
		begin : gen_mst
			// response held while the master stalls
			r_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
				i_s_rvalid[m] && !i_s_rready[m] |=>
				i_s_rvalid[m] && $stable(i_s_rdata[m]) && $stable(i_s_rresp[m]))
			else $error("master %0d read response changed while stalled", m);
		end

		for (s = 0; s < `XBAR_NS; s++)
		begin : gen_slv
			logic [`XBAR_NM-1:0] owners;

			for (m = 0; m < `XBAR_NM; m++)
			begin : gen_own
				assign owners[m] = i_grant[m][s];
			end

			ar_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
				i_m_arvalid[s] && !i_m_arready[s] |=>
				i_m_arvalid[s] && $stable(i_m_araddr[s]) && $stable(i_m_arprot[s]))
			else $error("slave %0d read address changed while stalled", s);

			// one owner per slave at most
			one_owner: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
				$onehot0(owners))
			else $error("slave %0d granted to more than one master", s);
		end
	endgenerate

	reset_idle: assert property (@(posedge S_AXI_ACLK)
		!S_AXI_ARESETN |=> (i_s_rvalid == '0) && (i_m_arvalid == '0))
	else $error("valid outputs high after reset");

endmodule

bind axil_rd_xbar axil_rd_xbar_assert assert_inst (
	.S_AXI_ACLK(S_AXI_ACLK),
	.S_AXI_ARESETN(S_AXI_ARESETN),
	.i_s_rvalid(S_AXI_RVALID),
	.i_s_rready(S_AXI_RREADY),
	.i_s_rdata(S_AXI_RDATA),
	.i_s_rresp(S_AXI_RRESP),
	.i_m_arvalid(M_AXI_ARVALID),
	.i_m_arready(M_AXI_ARREADY),
	.i_m_araddr(M_AXI_ARADDR),
	.i_m_arprot(M_AXI_ARPROT),
	.i_grant(grant)
);

// ==== dv/axil_rd_xbar_tb.sv ====
`timescale 1ns/1ps
`include "xbar_cfg.svh"

module axil_rd_xbar_tb;

	localparam int TIMEOUT = 200;

	logic                                  S_AXI_ACLK;
	logic                                  S_AXI_ARESETN;
	logic            [`XBAR_NM-1:0]        s_arvalid;
	logic            [`XBAR_NM-1:0]        s_arready;
	xbar_pkg::addr_t [`XBAR_NM-1:0]        s_araddr;
	xbar_pkg::prot_t [`XBAR_NM-1:0]        s_arprot;
	logic            [`XBAR_NM-1:0]        s_rvalid;
	logic            [`XBAR_NM-1:0]        s_rready;
	xbar_pkg::data_t [`XBAR_NM-1:0]        s_rdata;
	xbar_pkg::resp_t [`XBAR_NM-1:0]        s_rresp;
	logic            [`XBAR_NS-1:0]        m_arvalid;
	logic            [`XBAR_NS-1:0]        m_arready;
	xbar_pkg::addr_t [`XBAR_NS-1:0]        m_araddr;
	xbar_pkg::prot_t [`XBAR_NS-1:0]        m_arprot;
	logic            [`XBAR_NS-1:0]        m_rvalid;
	logic            [`XBAR_NS-1:0]        m_rready;
	xbar_pkg::data_t [`XBAR_NS-1:0]        m_rdata;
	xbar_pkg::resp_t [`XBAR_NS-1:0]        m_rresp;

	logic [15:0]     lfsr;
	int              err_data;
	int              err_resp;
	int              err_prot;
	int              err_other;
	int              arvalid_seen;
	xbar_pkg::data_t exp_data [`XBAR_NM][$];
	xbar_pkg::resp_t exp_resp [`XBAR_NM][$];

	// slave model state
	logic            rst_smp;
	logic            ar_take [`XBAR_NS];
	logic            r_take [`XBAR_NS];
	xbar_pkg::addr_t addr_smp [`XBAR_NS];
	xbar_pkg::prot_t prot_smp [`XBAR_NS];
	xbar_pkg::addr_t mdl_addr [`XBAR_NS];
	logic            mdl_busy [`XBAR_NS];
	int              mdl_wait [`XBAR_NS];

	axil_rd_xbar axil_rd_xbar_inst (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_ARVALID(s_arvalid), .S_AXI_ARREADY(s_arready),
		.S_AXI_ARADDR(s_araddr), .S_AXI_ARPROT(s_arprot),
		.S_AXI_RVALID(s_rvalid), .S_AXI_RREADY(s_rready),
		.S_AXI_RDATA(s_rdata), .S_AXI_RRESP(s_rresp),
		.M_AXI_ARVALID(m_arvalid), .M_AXI_ARREADY(m_arready),
		.M_AXI_ARADDR(m_araddr), .M_AXI_ARPROT(m_arprot),
		.M_AXI_RVALID(m_rvalid), .M_AXI_RREADY(m_rready),
		.M_AXI_RDATA(m_rdata), .M_AXI_RRESP(m_rresp)
	);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #2 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic xbar_pkg::data_t slave_key(input int s);
		return (s == 0) ? 32'h5a5a_0f0f : 32'hc3c3_1234;
	endfunction

	function automatic xbar_pkg::addr_t make_addr(input logic [`XBAR_RGN_W-1:0] rgn);
		xbar_pkg::addr_t a;
		logic [31:0]     r;
		r = rand_bits(`XBAR_AW - `XBAR_RGN_W);
		a.word = {rgn, r[`XBAR_AW-`XBAR_RGN_W-1:0]};
		return a;
	endfunction

	// prot taken from address bits, checked again at the slave
	function automatic xbar_pkg::prot_t prot_for_addr(input xbar_pkg::addr_t a);
		return a.word[6:4];
	endfunction

	// expected read data from the address map
	function automatic xbar_pkg::data_t expect_data(input xbar_pkg::addr_t a);
		logic [`XBAR_RGN_W-1:0] rgn;
		rgn = a.word[`XBAR_AW-1 -: `XBAR_RGN_W];
		if (rgn == `XBAR_SLV0_RGN)
			return a.word ^ slave_key(0);
		if (rgn == `XBAR_SLV1_RGN)
			return a.word ^ slave_key(1);
		return '0;
	endfunction

	function automatic xbar_pkg::resp_t expect_resp(input xbar_pkg::addr_t a);
		logic [`XBAR_RGN_W-1:0] rgn;
		rgn = a.word[`XBAR_AW-1 -: `XBAR_RGN_W];
		if (rgn == `XBAR_SLV0_RGN || rgn == `XBAR_SLV1_RGN)
			return 2'b00;
		return `XBAR_ERR_RESP;
	endfunction

	// slave models, one read at a time with a 0 to 3 cycle delay
	initial
	begin
		m_arready = '1;
		m_rvalid  = '0;
		m_rdata   = '0;
		m_rresp   = '0;
		for (int s = 0; s < `XBAR_NS; s++)
		begin
			mdl_busy[s] = 1'b0;
			mdl_wait[s] = 0;
		end
		forever
		begin
			@(negedge S_AXI_ACLK);
			rst_smp = S_AXI_ARESETN;
			for (int s = 0; s < `XBAR_NS; s++)
			begin
				ar_take[s]  = m_arvalid[s] && m_arready[s];
				r_take[s]   = m_rvalid[s] && m_rready[s];
				addr_smp[s] = m_araddr[s];
				prot_smp[s] = m_arprot[s];
			end
			@(posedge S_AXI_ACLK);
			#1;
			for (int s = 0; s < `XBAR_NS; s++)
			begin
				if (!rst_smp)
				begin
					m_arready[s] = 1'b1;
					m_rvalid[s]  = 1'b0;
					mdl_busy[s]  = 1'b0;
				end
				else
				begin
					if (r_take[s])
					begin
						m_rvalid[s]  = 1'b0;
						m_arready[s] = 1'b1;
					end
					if (ar_take[s])
					begin
						compare_prot(s, prot_smp[s], prot_for_addr(addr_smp[s]));
						m_arready[s] = 1'b0;
						mdl_addr[s]  = addr_smp[s];
						mdl_wait[s]  = rand_bits(2);
						mdl_busy[s]  = 1'b1;
					end
					if (mdl_busy[s] && mdl_wait[s] == 0)
					begin
						m_rvalid[s] = 1'b1;
						m_rdata[s]  = mdl_addr[s].word ^ slave_key(s);
						m_rresp[s]  = 2'b00;
						mdl_busy[s] = 1'b0;
					end
					else if (mdl_busy[s])
						mdl_wait[s] = mdl_wait[s] - 1;
				end
			end
		end
	end

	// counts cycles with any slave read address valid
	initial
	begin
		arvalid_seen = 0;
		forever
		begin
			@(negedge S_AXI_ACLK);
			if (|m_arvalid)
				arvalid_seen = arvalid_seen + 1;
		end
	end

	task automatic compare_data(input int m, input xbar_pkg::data_t got,
		input xbar_pkg::data_t want);
		if (got !== want)
		begin
			$display("mismatch at %0t: master %0d read data %h, expected %h",
				$time, m, got, want);
			err_data++;
		end
	endtask

	task automatic compare_resp(input int m, input xbar_pkg::resp_t got,
		input xbar_pkg::resp_t want);
		if (got !== want)
		begin
			$display("mismatch at %0t: master %0d read response %b, expected %b",
				$time, m, got, want);
			err_resp++;
		end
	endtask

	task automatic compare_prot(input int s, input xbar_pkg::prot_t got,
		input xbar_pkg::prot_t want);
		if (got !== want)
		begin
			$display("mismatch at %0t: slave %0d read prot %b, expected %b",
				$time, s, got, want);
			err_prot++;
		end
	endtask

	task automatic issue_read(input int m, input xbar_pkg::addr_t a);
		int   cnt;
		logic done;
		exp_data[m].push_back(expect_data(a));
		exp_resp[m].push_back(expect_resp(a));
		s_arvalid[m] = 1'b1;
		s_araddr[m]  = a;
		s_arprot[m]  = prot_for_addr(a);
		cnt  = 0;
		done = 1'b0;
		while (!done && cnt < TIMEOUT)
		begin
			@(negedge S_AXI_ACLK);
			done = s_arready[m];
			@(posedge S_AXI_ACLK);
			#1;
			cnt++;
		end
		s_arvalid[m] = 1'b0;
		if (!done)
		begin
			$display("master %0d read address was never accepted, at %0t", m, $time);
			err_other++;
		end
	endtask

	// responses must come back in issue order
	task automatic collect_reads(input int m, input int count, input bit backpressure);
		int              cnt;
		logic            got;
		logic            lost;
		xbar_pkg::data_t rd;
		xbar_pkg::resp_t rr;
		lost = 1'b0;
		for (int i = 0; i < count && !lost; i++)
		begin
			cnt = 0;
			got = 1'b0;
			while (!got && cnt < TIMEOUT)
			begin
				@(negedge S_AXI_ACLK);
				got = s_rvalid[m] && s_rready[m];
				rd  = s_rdata[m];
				rr  = s_rresp[m];
				@(posedge S_AXI_ACLK);
				#1;
				cnt++;
				if (backpressure)
					s_rready[m] = (rand_bits(1) != 0);
			end
			if (!got)
			begin
				$display("master %0d read response %0d never arrived, at %0t", m, i, $time);
				err_other++;
				lost = 1'b1;
			end
			else if (exp_data[m].size() == 0)
			begin
				$display("master %0d got a response with no read issued, at %0t", m, $time);
				err_other++;
			end
			else
			begin
				compare_data(m, rd, exp_data[m].pop_front());
				compare_resp(m, rr, exp_resp[m].pop_front());
			end
		end
		s_rready[m] = 1'b1;
	endtask

	task automatic run_master(input int m, input int count,
		input logic [`XBAR_RGN_W-1:0] rgn, input bit backpressure);
		exp_data[m].delete();
		exp_resp[m].delete();
		fork
			begin
				for (int i = 0; i < count; i++)
					issue_read(m, make_addr(rgn));
			end
			collect_reads(m, count, backpressure);
		join
	endtask

	task automatic check_idle();
		for (int i = 0; i < 8; i++)
		begin
			@(negedge S_AXI_ACLK);
			if (|s_rvalid)
			begin
				$display("extra read response on a master port at %0t", $time);
				err_other++;
			end
			@(posedge S_AXI_ACLK);
			#1;
		end
	endtask

	task automatic single_reads();
		run_master(0, 1, `XBAR_SLV0_RGN, 1'b0);
		run_master(1, 1, `XBAR_SLV1_RGN, 1'b0);
		run_master(0, 1, `XBAR_SLV1_RGN, 1'b0);
		run_master(1, 1, `XBAR_SLV0_RGN, 1'b0);
		check_idle();
	endtask

	task automatic unmapped_region();
		int seen;
		seen = arvalid_seen;
		run_master(0, 2, 4'h5, 1'b0);
		run_master(1, 1, 4'h5, 1'b0);
		check_idle();
		if (arvalid_seen != seen)
		begin
			$display("slave read address issued for an unmapped read");
			err_other++;
		end
	endtask

	task automatic shared_slave();
		fork
			run_master(0, 4, `XBAR_SLV0_RGN, 1'b0);
			run_master(1, 4, `XBAR_SLV0_RGN, 1'b0);
		join
		check_idle();
	endtask

	task automatic stalled_master();
		run_master(0, 4, `XBAR_SLV0_RGN, 1'b1);
		check_idle();
	endtask

	task automatic parallel_traffic();
		fork
			run_master(0, 6, `XBAR_SLV0_RGN, 1'b0);
			run_master(1, 6, `XBAR_SLV1_RGN, 1'b0);
		join
		fork
			run_master(0, 6, `XBAR_SLV1_RGN, 1'b0);
			run_master(1, 6, `XBAR_SLV0_RGN, 1'b0);
		join
		check_idle();
	endtask

	initial
	begin
		lfsr          = 16'd27872;
		err_data      = 0;
		err_resp      = 0;
		err_prot      = 0;
		err_other     = 0;
		S_AXI_ARESETN = 1'b0;
		s_arvalid     = '0;
		s_araddr      = '0;
		s_arprot      = '0;
		s_rready      = '1;
		repeat (2) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;

		single_reads();
		unmapped_region();
		shared_slave();
		stalled_master();
		parallel_traffic();

		$display("errors: %0d data, %0d response, %0d prot, %0d other",
			err_data, err_resp, err_prot, err_other);
		if (err_data + err_resp + err_prot + err_other == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+logic
logic/xbar_pkg.sv
logic/rd_skid_buffer.sv
logic/rd_addr_decode.sv
logic/rd_master_arbiter.sv
logic/rd_slave_port.sv
logic/rd_return_channel.sv
logic/axil_rd_xbar.sv
dv/axil_rd_xbar_assert.sv
dv/axil_rd_xbar_tb.sv

// ==== Makefile ====
TOP := axil_rd_xbar_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
